/* debug_pkg.sv */
`default_nettype none

package debug_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////
  localparam int DATA_W       = 32;         // instruction and cycle counter
  localparam int BYTE_W       = 8;          // uart byte
  localparam int INST_ADDR_W  = 7;          // instruction memory depth 128
  localparam int BUCKET_BYTES = 4;
  localparam int BUCKET_W     = BUCKET_BYTES * BYTE_W;

  // bytes per instruction word sent lsb first
  localparam int WORD_BYTES = DATA_W / BYTE_W;
  localparam int LANE_W     = $clog2(WORD_BYTES);
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(WORD_BYTES - 1);

  // bucket byte index
  localparam int SEND_IDX_W = $clog2(BUCKET_BYTES);
  localparam logic [SEND_IDX_W-1:0] LAST_SEND_IDX = SEND_IDX_W'(BUCKET_BYTES - 1);

  ////////////////////////////////////////////////////////////
  // program end marker
  ////////////////////////////////////////////////////////////
  localparam int OPCODE_LSB = 26;             // opcode field is [31:26]
  localparam logic [5:0] HALT_OPCODE = 6'b111111;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////
  typedef enum logic [7:0] {
    CMD_START        = 8'd1,
    CMD_CONTINUOUS   = 8'd2,
    CMD_STEP_BY_STEP = 8'd3,
    CMD_REPROGRAM    = 8'd5,
    CMD_STEP         = 8'd6
  } host_cmd_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_PROGRAMMING,
    ST_WAITING,
    ST_STEP_BY_STEP,
    ST_CONTINUOUS,
    ST_SENDING
  } debug_state_e;

  // code seen by the cpu clock gate
  typedef enum logic [1:0] {
    CLK_HOLD = 2'd0,
    CLK_STEP = 2'd1,
    CLK_RUN  = 2'd2
  } clk_mode_e;

endpackage

`default_nettype wire

/* loader_if.sv */
`timescale 1ns/1ps
`default_nettype none

// byte stream from the sequencer into the program loader
interface loader_if;

  logic                         load_en;     // high while programming
  logic                         byte_valid;  // gated rx strobe
  logic [debug_pkg::BYTE_W-1:0] byte_data;
  logic                         load_done;   // halt word written

  modport sequencer (
    output load_en,
    output byte_valid,
    output byte_data,
    input  load_done
  );

  modport loader (
    input  load_en,
    input  byte_valid,
    input  byte_data,
    output load_done
  );

endinterface

`default_nettype wire

/* debug_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_sequencer
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         halt,          // cpu reached end of program
  input  logic                         rx_done_tick,
  input  logic [debug_pkg::BYTE_W-1:0] rx_data,
  loader_if.sequencer                  ld,
  output logic                         step_req,
  output logic                         run_en,
  output logic                         count_clear,
  output logic                         send_req,
  input  logic                         send_done,
  output logic                         debug
);

  debug_pkg::debug_state_e state;
  debug_pkg::debug_state_e state_next;
  logic                    in_prog;

  ////////////////////////////////////////////////////////////
  // state register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (reset)
      state <= debug_pkg::ST_IDLE;
    else
      state <= state_next;
  end

  ////////////////////////////////////////////////////////////
  // command decode and next state
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    state_next = state;
    step_req   = 1'b0;
    send_req   = 1'b0;
    case (state)
      debug_pkg::ST_IDLE:
      begin
        if (rx_done_tick && (rx_data == debug_pkg::CMD_START))
          state_next = debug_pkg::ST_PROGRAMMING;   // other bytes dropped
      end
      debug_pkg::ST_PROGRAMMING:
      begin
        if (ld.load_done)
          state_next = debug_pkg::ST_WAITING;
      end
      debug_pkg::ST_WAITING:
      begin
        if (rx_done_tick)
        begin
          case (debug_pkg::host_cmd_e'(rx_data))
            debug_pkg::CMD_CONTINUOUS:   state_next = debug_pkg::ST_CONTINUOUS;
            debug_pkg::CMD_STEP_BY_STEP: state_next = debug_pkg::ST_STEP_BY_STEP;
            default:                     state_next = debug_pkg::ST_IDLE;  // reprogram or unknown
          endcase
        end
      end
      debug_pkg::ST_STEP_BY_STEP:
      begin
        if (rx_done_tick && (rx_data == debug_pkg::CMD_STEP))
        begin
          step_req   = 1'b1;                 // one cpu clock
          send_req   = 1'b1;                 // report state right after
          state_next = debug_pkg::ST_SENDING;
        end
      end
      debug_pkg::ST_CONTINUOUS:
      begin
        if (halt)
        begin
          send_req   = 1'b1;
          state_next = debug_pkg::ST_SENDING;
        end
      end
      debug_pkg::ST_SENDING:
      begin
        // host bytes are ignored until the bucket is out
        if (send_done)
          state_next = halt ? debug_pkg::ST_WAITING : debug_pkg::ST_STEP_BY_STEP;
      end
      default:
        state_next = debug_pkg::ST_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // levels to the other blocks
  ////////////////////////////////////////////////////////////
  assign in_prog = (state == debug_pkg::ST_PROGRAMMING);

  assign run_en      = (state == debug_pkg::ST_CONTINUOUS) && !halt;
  assign count_clear = (state == debug_pkg::ST_IDLE) || in_prog ||
                       (state == debug_pkg::ST_WAITING);
  assign debug       = in_prog;              // memory being written

  // loader only sees bytes while programming
  assign ld.load_en    = in_prog;
  assign ld.byte_valid = rx_done_tick && in_prog;
  assign ld.byte_data  = rx_data;

endmodule

`default_nettype wire

/* program_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module program_loader
(
  input  logic                              clk,
  input  logic                              reset,
  loader_if.loader                          ld,
  output logic [debug_pkg::DATA_W-1:0]      ins_to_mem,    // assembled word
  output logic [debug_pkg::INST_ADDR_W-1:0] addr_mem_inst, // write address
  output logic                              wr_ram_inst    // one cycle per word
);

  logic [debug_pkg::LANE_W-1:0] lane;        // next byte position
  logic                         word_full;

  assign word_full = ld.byte_valid && (lane == debug_pkg::LAST_LANE);

  ////////////////////////////////////////////////////////////
  // lane, address and write strobe
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      lane          <= '0;
      addr_mem_inst <= '0;
      wr_ram_inst   <= 1'b0;
    end
    else
    begin
      wr_ram_inst <= word_full;
      if (!ld.load_en)
      begin
        lane          <= '0;                 // restart at address 0
        addr_mem_inst <= '0;
      end
      else
      begin
        if (ld.byte_valid)
          lane <= lane + 1'b1;               // wraps after the msb
        if (wr_ram_inst)
          addr_mem_inst <= addr_mem_inst + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // byte assembly with the first byte least significant
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (ld.byte_valid)
      ins_to_mem[lane*debug_pkg::BYTE_W +: debug_pkg::BYTE_W] <= ld.byte_data;
  end

  // halt opcode ends the program in the same cycle as its write
  assign ld.load_done = wr_ram_inst &&
    (ins_to_mem[debug_pkg::DATA_W-1:debug_pkg::OPCODE_LSB] == debug_pkg::HALT_OPCODE);

endmodule

`default_nettype wire

/* cpu_clock_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_clock_ctrl
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         step_req,     // single cpu clock
  input  logic                         run_en,       // free running
  input  logic                         count_clear,
  output debug_pkg::clk_mode_e         ctrl_clk_mips,
  output logic [debug_pkg::DATA_W-1:0] cycle_count
);

  logic tick;                                // cpu gets a clock next cycle

  assign tick = step_req || run_en;

  ////////////////////////////////////////////////////////////
  // clock-control code
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (reset)
      ctrl_clk_mips <= debug_pkg::CLK_HOLD;
    else if (step_req)
      ctrl_clk_mips <= debug_pkg::CLK_STEP;
    else if (run_en)
      ctrl_clk_mips <= debug_pkg::CLK_RUN;
    else
      ctrl_clk_mips <= debug_pkg::CLK_HOLD;
  end

  ////////////////////////////////////////////////////////////
  // cpu cycle counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (reset || count_clear)
      cycle_count <= '0;
    else if (tick)
      cycle_count <= cycle_count + 1'b1;     // tracks the code above
  end

endmodule

`default_nettype wire

/* bucket_sender.sv */
`timescale 1ns/1ps
`default_nettype none

module bucket_sender
(
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           send_req,
  input  logic [debug_pkg::BUCKET_W-1:0] bucket,
  input  logic                           tx_done_tick,  // uart finished a byte
  output logic                           tx_start,
  output logic [debug_pkg::BYTE_W-1:0]   tx_data,
  output logic                           send_done
);

  logic [debug_pkg::BUCKET_W-1:0]   bucket_q;   // snapshot at send start
  logic [debug_pkg::SEND_IDX_W-1:0] byte_idx;
  logic                             byte_sent;
  logic                             last_byte;

  assign byte_sent = tx_start && tx_done_tick;
  assign last_byte = byte_sent && (byte_idx == debug_pkg::LAST_SEND_IDX);

  ////////////////////////////////////////////////////////////
  // byte sequencing
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      tx_start  <= 1'b0;
      byte_idx  <= '0;
      send_done <= 1'b0;
    end
    else
    begin
      send_done <= last_byte;
      if (send_req)
      begin
        tx_start <= 1'b1;
        byte_idx <= '0;                      // lsb goes first
      end
      else if (byte_sent)
      begin
        byte_idx <= byte_idx + 1'b1;
        if (last_byte)
          tx_start <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (send_req)
      bucket_q <= bucket;
  end

  assign tx_data = bucket_q[byte_idx*debug_pkg::BYTE_W +: debug_pkg::BYTE_W];

endmodule

`default_nettype wire

/* debug_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_unit
(
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              halt,
  input  logic [debug_pkg::BUCKET_W-1:0]    bucket,
  // uart side
  input  logic                              rx_done_tick,
  input  logic [debug_pkg::BYTE_W-1:0]      rx_data,
  input  logic                              tx_done_tick,
  output logic                              tx_start,
  output logic [debug_pkg::BYTE_W-1:0]      tx_data,
  // cpu side
  output logic [debug_pkg::DATA_W-1:0]      ins_to_mem,
  output logic [debug_pkg::INST_ADDR_W-1:0] addr_mem_inst,
  output logic                              wr_ram_inst,
  output logic [1:0]                        ctrl_clk_mips,
  output logic                              debug,
  output logic [debug_pkg::DATA_W-1:0]      cycle_count
);

  logic step_req;
  logic run_en;
  logic count_clear;
  logic send_req;
  logic send_done;

  loader_if ld ();

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////
  debug_sequencer u_sequencer (
    .clk          (clk),
    .reset        (reset),
    .halt         (halt),
    .rx_done_tick (rx_done_tick),
    .rx_data      (rx_data),
    .ld           (ld.sequencer),
    .step_req     (step_req),
    .run_en       (run_en),
    .count_clear  (count_clear),
    .send_req     (send_req),
    .send_done    (send_done),
    .debug        (debug)
  );

  ////////////////////////////////////////////////////////////
  // datapath blocks
  ////////////////////////////////////////////////////////////
  program_loader u_loader (
    .clk           (clk),
    .reset         (reset),
    .ld            (ld.loader),
    .ins_to_mem    (ins_to_mem),
    .addr_mem_inst (addr_mem_inst),
    .wr_ram_inst   (wr_ram_inst)
  );

  cpu_clock_ctrl u_clock_ctrl (
    .clk           (clk),
    .reset         (reset),
    .step_req      (step_req),
    .run_en        (run_en),
    .count_clear   (count_clear),
    .ctrl_clk_mips (ctrl_clk_mips),   // enum code onto the 2-bit port
    .cycle_count   (cycle_count)
  );

  bucket_sender u_sender (
    .clk          (clk),
    .reset        (reset),
    .send_req     (send_req),
    .bucket       (bucket),
    .tx_done_tick (tx_done_tick),
    .tx_start     (tx_start),
    .tx_data      (tx_data),
    .send_done    (send_done)
  );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// 10 ns clock and a reset held for the first 16 rising edges
module tb_clock_gen
(
  output logic clk,
  output logic reset
);

  initial
  begin
    clk   = 1'b0;
    reset = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);                          // release away from the sampling edge
    reset = 1'b0;
  end

  always #5 clk = ~clk;

endmodule

`default_nettype wire

/* debug_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_unit_tb;

  localparam int MAX_CYCLES = 20000;         // all six tests need well under 2000
  localparam int SEED       = 4997;

  logic                              clk;
  logic                              reset;
  logic                              halt;
  logic [debug_pkg::BUCKET_W-1:0]    bucket;
  logic                              rx_done_tick;
  logic [debug_pkg::BYTE_W-1:0]      rx_data;
  logic                              tx_done_tick;
  logic                              tx_start;
  logic [debug_pkg::BYTE_W-1:0]      tx_data;
  logic [debug_pkg::DATA_W-1:0]      ins_to_mem;
  logic [debug_pkg::INST_ADDR_W-1:0] addr_mem_inst;
  logic                              wr_ram_inst;
  logic [1:0]                        ctrl_clk_mips;
  logic                              debug;
  logic [debug_pkg::DATA_W-1:0]      cycle_count;

  logic [7:0]  tx_q [$];                     // bytes seen by the uart model
  logic [6:0]  wr_addr_q [$];
  logic [31:0] wr_data_q [$];
  int          step_cnt = 0;
  int          run_cnt = 0;
  int          tx_gap;
  int          test_errors = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          cycles = 0;
  logic [31:0] exp_bucket;

  tb_clock_gen clock_gen (.clk(clk), .reset(reset));

  debug_unit UUT (
    .clk           (clk),
    .reset         (reset),
    .halt          (halt),
    .bucket        (bucket),
    .rx_done_tick  (rx_done_tick),
    .rx_data       (rx_data),
    .tx_done_tick  (tx_done_tick),
    .tx_start      (tx_start),
    .tx_data       (tx_data),
    .ins_to_mem    (ins_to_mem),
    .addr_mem_inst (addr_mem_inst),
    .wr_ram_inst   (wr_ram_inst),
    .ctrl_clk_mips (ctrl_clk_mips),
    .debug         (debug),
    .cycle_count   (cycle_count)
  );

  ////////////////////////////////////////////////////////////
  // monitors and uart model
  ////////////////////////////////////////////////////////////
  always @(negedge clk)
  begin
    if (wr_ram_inst)
    begin
      wr_addr_q.push_back(addr_mem_inst);
      wr_data_q.push_back(ins_to_mem);
    end
    if (ctrl_clk_mips == debug_pkg::CLK_STEP)
      step_cnt++;
    if (ctrl_clk_mips == debug_pkg::CLK_RUN)
      run_cnt++;
  end

  always
  begin
    @(negedge clk);
    if (tx_start)
    begin
      tx_gap = $urandom_range(1, 8);
      repeat (tx_gap - 1) @(negedge clk);
      tx_q.push_back(tx_data);
      tx_done_tick = 1'b1;
      @(negedge clk);
      tx_done_tick = 1'b0;
    end
  end

  initial
  begin
    while (cycles < MAX_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  task automatic check(input bit ok, input string msg);
    assert (ok)
    else
    begin
      $display("[ERROR] %0t %s", $time, msg);
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0)
    begin
      $display("test %s: ok", name);
      pass_cnt++;
    end
    else
    begin
      $display("test %s: %0d errors", name, test_errors);
      fail_cnt++;
    end
    test_errors = 0;
  endtask

  // one host byte as a one-cycle strobe after a random gap
  task automatic send_byte(input logic [7:0] b);
    int gap;
    gap = $urandom_range(0, 3);
    repeat (gap) @(negedge clk);
    rx_data      = b;
    rx_done_tick = 1'b1;
    @(negedge clk);
    rx_done_tick = 1'b0;
  endtask

  task automatic load_program(input int n_words);
    logic [31:0] w;
    logic [31:0] words [$];
    wr_addr_q.delete();
    wr_data_q.delete();
    send_byte(debug_pkg::CMD_START);
    check(debug, "debug low after start command");
    for (int i = 0; i < n_words; i++)
    begin
      w     = $urandom();
      w[31] = 1'b0;                          // keeps the halt opcode out
      if (i == n_words - 1)
        w[31:26] = debug_pkg::HALT_OPCODE;
      words.push_back(w);
      for (int b = 0; b < 4; b++)
      begin
        check(debug, "debug dropped during load");
        send_byte(w[8*b +: 8]);
      end
    end
    @(negedge clk);
    check(!debug, "debug still high after halt word");
    repeat (4) @(negedge clk);
    check(wr_addr_q.size() == n_words, $sformatf("%0d writes seen", wr_addr_q.size()));
    for (int i = 0; i < n_words; i++)
      if (i < wr_addr_q.size())
        check(wr_addr_q[i] == i && wr_data_q[i] == words[i],
              $sformatf("write %0d: addr %0d data %h, expected %h", i, wr_addr_q[i],
                        wr_data_q[i], words[i]));
  endtask

  task automatic wait_send();
    int n;
    n = 0;
    while ((tx_q.size() < 4 || tx_start) && n < 100)
    begin
      @(negedge clk);
      n++;
    end
    if (n >= 100)
    begin
      $display("bucket send did not finish, stuck at %0t", $time);
      test_errors++;
    end
    repeat (3) @(negedge clk);
  endtask

  task automatic check_bytes(input logic [31:0] exp);
    check(tx_q.size() == 4, $sformatf("%0d tx bytes instead of 4", tx_q.size()));
    for (int i = 0; i < 4; i++)
      if (i < tx_q.size())
        check(tx_q[i] == exp[8*i +: 8],
              $sformatf("tx byte %0d is %h, expected %h", i, tx_q[i], exp[8*i +: 8]));
  endtask

  task automatic do_step(input logic [31:0] exp_count);
    int steps_before;
    steps_before = step_cnt;
    exp_bucket   = $urandom();
    bucket       = exp_bucket;
    tx_q.delete();
    send_byte(debug_pkg::CMD_STEP);
    check(ctrl_clk_mips == debug_pkg::CLK_STEP, "no step clock after step command");
    check(cycle_count == exp_count, $sformatf("cycle count %0d, expected %0d",
                                              cycle_count, exp_count));
    check(tx_start, "tx_start low after step");
    bucket = ~exp_bucket;                    // sender must hold its snapshot
    wait_send();
    check(step_cnt == steps_before + 1, "step clock not exactly one cycle");
    check_bytes(exp_bucket);
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////
  initial
  begin
    void'($urandom(SEED));
    halt         = 1'b0;
    bucket       = '0;
    rx_done_tick = 1'b0;
    rx_data      = '0;
    tx_done_tick = 1'b0;
    @(negedge clk);
    while (reset)
      @(negedge clk);

    check(!wr_ram_inst && !tx_start && !debug, "strobe or level active after reset");
    check(ctrl_clk_mips == debug_pkg::CLK_HOLD && cycle_count == 0, "clock code or count set");
    send_byte(debug_pkg::CMD_STEP);
    repeat (2) @(negedge clk);
    check(!debug, "stray byte in idle raised debug");
    end_test("reset and idle");

    load_program(5);
    end_test("program load");

    send_byte(debug_pkg::CMD_STEP_BY_STEP);
    do_step(1);
    do_step(2);
    end_test("step mode");

    halt = 1'b1;
    do_step(3);
    check(cycle_count == 0, "count not cleared, unit not waiting");
    halt = 1'b0;
    end_test("halt in step mode");

    exp_bucket = $urandom();
    bucket     = exp_bucket;
    run_cnt    = 0;
    tx_q.delete();
    send_byte(debug_pkg::CMD_CONTINUOUS);
    repeat ($urandom_range(10, 60)) @(negedge clk);
    halt = 1'b1;
    for (int n = 0; n < 10 && !tx_start; n++)
      @(negedge clk);
    check(tx_start, "no bucket send after halt");
    check(run_cnt > 0, "continuous command not accepted");
    check(cycle_count == run_cnt, $sformatf("cycle count %0d, run cycles %0d",
                                            cycle_count, run_cnt));
    bucket = ~exp_bucket;
    wait_send();
    check_bytes(exp_bucket);
    end_test("continuous run");

    send_byte(debug_pkg::CMD_REPROGRAM);
    @(negedge clk);
    check(!debug, "debug high after reprogram");
    halt = 1'b0;
    load_program(2);
    end_test("reprogram");

    $display("%0d tests ok, %0d tests with errors", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
debug_pkg.sv
loader_if.sv
debug_sequencer.sv
program_loader.sv
cpu_clock_ctrl.sv
bucket_sender.sv
debug_unit.sv
tb_clock_gen.sv
debug_unit_tb.sv
